// ==== sim.f ====
src/chart_pkg.sv
src/play_pkg.sv
src/note_queue.sv
src/step_timer.sv
src/play_fsm.sv
src/score_judge.sv
src/note_voice.sv
src/chart_player.sv
tests/chart_player_checker.sv
tests/chart_player_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module chart_player_tb -f sim.f -o chart_player_sim

out=$(./obj_dir/chart_player_sim)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
    exit 0
else
    exit 1
fi

// ==== tests/chart_player_tb.sv ====
`timescale 1ns/1ns

module chart_player_tb;

    localparam int NUM_ROWS = 32;
    localparam int EXIT_INDEX = 4;
    localparam int STEP_WAIT = 4 * play_pkg::STEP_CYCLES;
    localparam int GAME_WAIT = (play_pkg::COUNTDOWN_STEPS + 8) * play_pkg::STEP_CYCLES;
    localparam int WATCHDOG_NS =
        (NUM_ROWS + play_pkg::COUNTDOWN_STEPS) * play_pkg::STEP_CYCLES * 2 * 20;

    logic prog_clk = 1'b0;
    logic rst;
    logic start;
    logic exit_req;
    play_pkg::index_t note_total;
    chart_pkg::note_t keys_in = '0;
    chart_pkg::note_t note_in = '0;
    logic note_valid = 1'b0;
    logic credit_ret;
    play_pkg::play_status_t status;
    play_pkg::score_t score;
    chart_pkg::led_t led;
    logic tone;

    // Stimulus table of chart note, lag of the player hit, derived keys and points
    chart_pkg::note_t chart [NUM_ROWS];
    int lag [NUM_ROWS];
    chart_pkg::note_t player_keys [NUM_ROWS];
    play_pkg::score_t points [NUM_ROWS];
    int run_start [NUM_ROWS];
    int rows;
    logic [31:0] lcg_state = 32'hd958e760;

    int credits = play_pkg::QUEUE_DEPTH;
    int credit_count = 0;
    int src_ptr = 0;
    logic src_enable = 1'b0;
    int value_errors = 0;
    int other_errors = 0;
    int tone_checks = 0;

    chart_player UUT (.*);

    always #10 prog_clk = ~prog_clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // pos 7 gives a rest
    function automatic chart_pkg::note_t make_note(input int oct, input int pos);
        chart_pkg::note_t n;
        n.oct = chart_pkg::oct_t'(oct);
        n.keys = (pos < 7) ? chart_pkg::key_t'(1 << pos) : '0;
        return n;
    endfunction

    // C lights the top LED, B the one just above the octave bit
    function automatic chart_pkg::led_t expected_led(input chart_pkg::note_t n);
        chart_pkg::led_t l;
        l = '0;
        for (int pos = 0; pos < 7; pos++) begin
            if (n.keys[pos]) begin
                l = l | (chart_pkg::led_t'(8'h80) >> pos);
            end
        end
        if (n.keys != '0 && n.oct != 2'b00) begin
            l[0] = 1'b1;
        end
        return l;
    endfunction

    function automatic chart_pkg::half_period_t expected_half(input chart_pkg::note_t n);
        int pos;
        int hp;
        pos = 0;
        for (int i = 6; i >= 0; i--) begin
            if (n.keys[i]) pos = i;
        end
        hp = int'(chart_pkg::TONE_BASE) - 16 * pos;
        if (n.oct == 2'b10) hp = hp * 2;
        if (n.oct == 2'b01) hp = hp / 2;
        return chart_pkg::half_period_t'(hp);
    endfunction

    function automatic chart_pkg::note_t key_at(input int j);
        return (j < 0) ? chart_pkg::note_t'('0) : player_keys[j];
    endfunction

    function automatic play_pkg::score_t row_points(input int i);
        if (chart[i].keys == '0) return '0;
        if (chart[i] == key_at(i) || chart[i] == key_at(i - 1)) return play_pkg::PTS_EXACT;
        if (chart[i] == key_at(i - 2)) return play_pkg::PTS_LATE1;
        if (chart[i] == key_at(i - 3)) return play_pkg::PTS_LATE2;
        return '0;
    endfunction

    task automatic add_row(input int oct, input int pos, input int l);
        chart[rows] = make_note(oct, pos);
        lag[rows] = l;
        rows++;
    endtask

    task automatic build_table();
        logic [31:0] r;
        rows = 0;
        add_row(0, 0, 0);
        add_row(0, 1, 0);
        add_row(0, 7, 0);
        add_row(0, 2, 1);
        add_row(0, 5, 4);
        add_row(1, 4, 2);
        add_row(0, 7, 0);
        add_row(2, 3, 3);
        // Long runs so the tone gets several edges
        repeat (6) add_row(1, 6, 0);
        repeat (8) add_row(0, 6, 0);
        while (rows < NUM_ROWS) begin
            r = lcg_next();
            add_row(int'((r >> 4) % 3), int'(r % 8), int'((r >> 8) % 5));
        end
        // Lag 4 is a miss as the unused keys never match a chart note
        for (int i = 0; i < NUM_ROWS; i++) player_keys[i] = 9'h1ff;
        for (int i = 0; i < NUM_ROWS; i++) begin
            if (chart[i].keys != '0 && lag[i] < 4 && i >= lag[i]) begin
                player_keys[i - lag[i]] = chart[i];
            end
        end
        for (int i = 0; i < NUM_ROWS; i++) begin
            points[i] = row_points(i);
            run_start[i] = (i > 0 && chart[i] == chart[i - 1]) ? run_start[i - 1] : i;
        end
    endtask

    task automatic check_score(input string name, input play_pkg::score_t exp,
                               input play_pkg::score_t act);
        if (exp !== act) begin
            value_errors++;
            $display("ERR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_led(input string name, input chart_pkg::led_t exp,
                             input chart_pkg::led_t act);
        if (exp !== act) begin
            value_errors++;
            $display("ERR %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_state(input string name, input play_pkg::play_state_e exp,
                               input play_pkg::play_state_e act);
        if (exp !== act) begin
            value_errors++;
            $display("ERR %s: expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_half(input string name, input chart_pkg::half_period_t exp,
                              input chart_pkg::half_period_t act);
        if (exp !== act) begin
            value_errors++;
            $display("ERR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_digit(input string name, input play_pkg::digit_t exp,
                               input play_pkg::digit_t act);
        if (exp !== act) begin
            value_errors++;
            $display("ERR %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic wait_index(input int target, input int limit);
        int waited;
        waited = 0;
        while (int'(status.index) != target && waited < limit) begin
            @(negedge prog_clk);
            waited++;
        end
        if (int'(status.index) != target) begin
            other_errors++;
            $display("Note index never reached %0d", target);
        end
    endtask

    task automatic wait_done(input int limit);
        int waited;
        waited = 0;
        while (!status.done && waited < limit) begin
            @(negedge prog_clk);
            waited++;
        end
        if (!status.done) begin
            other_errors++;
            $display("Done flag never rose at the end of the chart");
        end
    endtask

    // Credit-driven note source
    always @(negedge prog_clk) begin
        if (credit_ret) begin
            credits++;
            credit_count++;
        end
        note_valid = 1'b0;
        if (src_enable && credits > 0 && src_ptr < NUM_ROWS) begin
            note_valid = 1'b1;
            note_in = chart[src_ptr];
            src_ptr++;
            credits--;
        end
    end

    // Player presses the keys planned for the step of the current index
    always @(negedge prog_clk) begin
        keys_in = (int'(status.index) < NUM_ROWS) ? player_keys[status.index] : '0;
    end

    int cycle_n = 0;
    int edge_cycle = 0;
    int edge_run = 0;
    logic edge_valid = 1'b0;
    logic tone_q = 1'b0;
    play_pkg::index_t index_q = '0;

    // Tone edge spacing within a run of equal notes and silence on rests
    always @(negedge prog_clk) begin
        int cur_idx;
        cycle_n++;
        if (status.state == play_pkg::PLAY && status.index != '0) begin
            cur_idx = int'(status.index) - 1;
            if (tone !== tone_q) begin
                if (edge_valid && edge_run == run_start[cur_idx]) begin
                    check_half($sformatf("tone half period row %0d", cur_idx),
                        expected_half(chart[cur_idx]),
                        chart_pkg::half_period_t'(cycle_n - edge_cycle));
                    tone_checks++;
                end
                edge_valid = 1'b1;
                edge_run = run_start[cur_idx];
                edge_cycle = cycle_n;
            end
            if (chart[cur_idx].keys == '0 && status.index == index_q && tone !== 1'b0) begin
                other_errors++;
                $display("Tone is high during the rest at row %0d", cur_idx);
            end
        end else begin
            edge_valid = 1'b0;
        end
        tone_q = tone;
        index_q = status.index;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Errors: value %0d, other %0d", value_errors, other_errors + 1);
        $display("Test failed");
        $finish;
    end

    initial begin
        play_pkg::digit_t seen [3];
        int n_digits;
        int waited;
        play_pkg::digit_t last_digit;
        play_pkg::score_t total;
        play_pkg::score_t prefix;

        rst = 1'b1;
        start = 1'b0;
        exit_req = 1'b0;
        note_total = '0;
        build_table();
        repeat (5) @(negedge prog_clk);
        rst = 1'b0;
        @(negedge prog_clk);
        check_state("state after reset", play_pkg::IDLE, status.state);
        check_score("score after reset", '0, score);
        check_led("led after reset", '0, led);
        if (status.done || tone) begin
            other_errors++;
            $display("Done or tone high after reset");
        end

        @(posedge prog_clk);
        src_enable = 1'b1;
        @(negedge prog_clk);
        note_total = play_pkg::index_t'(NUM_ROWS);
        start = 1'b1;
        @(negedge prog_clk);
        start = 1'b0;

        n_digits = 0;
        waited = 0;
        last_digit = '0;
        while (status.state != play_pkg::PLAY && waited < GAME_WAIT) begin
            if (status.state == play_pkg::COUNTDOWN && status.digit != last_digit) begin
                if (n_digits < 3) seen[n_digits] = status.digit;
                n_digits++;
                last_digit = status.digit;
            end
            @(negedge prog_clk);
            waited++;
        end
        check_state("state after countdown", play_pkg::PLAY, status.state);
        if (n_digits != 3) begin
            other_errors++;
            $display("Countdown showed %0d digits instead of 3", n_digits);
        end else begin
            for (int k = 0; k < 3; k++) begin
                check_digit("countdown digit", play_pkg::digit_t'(3 - k), seen[k]);
            end
        end

        total = '0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            wait_index(i + 1, STEP_WAIT);
            check_led($sformatf("led row %0d", i), expected_led(chart[i]), led);
            total = total + points[i];
        end
        wait_done(STEP_WAIT);
        check_state("state at end of chart", play_pkg::DONE, status.state);
        check_score("final score", total, score);
        repeat (3 * play_pkg::STEP_CYCLES) @(negedge prog_clk);
        check_state("state held after end", play_pkg::DONE, status.state);
        if (credit_count != NUM_ROWS) begin
            other_errors++;
            $display("Saw %0d credit returns for %0d notes", credit_count, NUM_ROWS);
        end
        if (tone_checks < 2) begin
            other_errors++;
            $display("Too few tone edges were measured");
        end

        // Second game, left early with exit_req
        @(posedge prog_clk);
        src_ptr = 0;
        @(negedge prog_clk);
        start = 1'b1;
        @(negedge prog_clk);
        start = 1'b0;
        wait_index(EXIT_INDEX, GAME_WAIT);
        prefix = '0;
        for (int i = 0; i < EXIT_INDEX; i++) prefix = prefix + points[i];
        check_score("score before exit", prefix, score);
        exit_req = 1'b1;
        @(negedge prog_clk);
        exit_req = 1'b0;
        check_state("state after exit", play_pkg::IDLE, status.state);
        check_score("score after exit", prefix, score);

        $display("Errors: value %0d, other %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tests/chart_player_checker.sv ====
`timescale 1ns/1ns

module chart_player_checker (
    input logic                    prog_clk,
    input logic                    rst,
    input logic                    exit_req,
    input play_pkg::index_t        note_total,
    input logic                    note_valid,
    input logic                    credit_ret,
    input logic                    pop,
    input play_pkg::play_status_t  status
);

    // Notes sent by the source and not yet paid back with a credit
    int outstanding;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(note_valid) - int'(credit_ret);
        end
    end

    a_outstanding: assert property (@(posedge prog_clk) disable iff (rst)
        outstanding <= play_pkg::QUEUE_DEPTH)
        else $error("More notes outstanding than queue entries");

    a_credit_after_pop: assert property (@(posedge prog_clk) disable iff (rst)
        credit_ret == $past(pop))
        else $error("Credit return does not follow a pop by one cycle");

    // Done only once every chart note was popped
    a_done_state: assert property (@(posedge prog_clk) disable iff (rst)
        status.done |-> status.state == play_pkg::DONE && status.index == note_total)
        else $error("Done flag high outside DONE or before the last note");

    a_pop_in_play: assert property (@(posedge prog_clk) disable iff (rst)
        pop && !exit_req |=> $past(status.state) == play_pkg::PLAY &&
            status.index == $past(status.index) + 1'b1)
        else $error("Pop outside the PLAY state or without an index step");

endmodule

bind chart_player chart_player_checker u_checker (
    .prog_clk   (prog_clk),
    .rst        (rst),
    .exit_req   (exit_req),
    .note_total (note_total),
    .note_valid (note_valid),
    .credit_ret (credit_ret),
    .pop        (pop),
    .status     (status)
);

// ==== src/chart_player.sv ====
`timescale 1ns/1ns

module chart_player (
    input  logic                    prog_clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic                    exit_req,
    input  play_pkg::index_t        note_total,
    input  chart_pkg::note_t        keys_in,
    input  chart_pkg::note_t        note_in,
    input  logic                    note_valid,
    output logic                    credit_ret,
    output play_pkg::play_status_t  status,
    output play_pkg::score_t        score,
    output chart_pkg::led_t         led,
    output logic                    tone
);

    chart_pkg::note_t head;
    play_pkg::index_t step_count;
    logic empty;
    logic pop;
    logic step;
    logic run;
    logic clear;
    logic playing;

    note_queue u_queue (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .note_in    (note_in),
        .note_valid (note_valid),
        .pop        (pop),
        .head       (head),
        .empty      (empty),
        .credit_ret (credit_ret)
    );

    step_timer u_timer (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .run        (run),
        .clear      (clear),
        .step       (step),
        .step_count (step_count)
    );

    play_fsm u_fsm (
        .prog_clk   (prog_clk),
        .rst        (rst),
        .start      (start),
        .exit_req   (exit_req),
        .note_total (note_total),
        .step       (step),
        .step_count (step_count),
        .empty      (empty),
        .pop        (pop),
        .run        (run),
        .clear      (clear),
        .playing    (playing),
        .status     (status)
    );

    score_judge u_judge (
        .prog_clk (prog_clk),
        .rst      (rst),
        .step     (step),
        .playing  (playing),
        .head     (head),
        .keys_in  (keys_in),
        .score    (score)
    );

    note_voice u_voice (
        .prog_clk (prog_clk),
        .rst      (rst),
        .pop      (pop),
        .playing  (playing),
        .head     (head),
        .led      (led),
        .tone     (tone)
    );

endmodule

// ==== src/note_voice.sv ====
`timescale 1ns/1ns

module note_voice (
    input  logic              prog_clk,
    input  logic              rst,
    input  logic              pop,
    input  logic              playing,
    input  chart_pkg::note_t  head,
    output chart_pkg::led_t   led,
    output logic              tone
);

    chart_pkg::note_t cur;
    chart_pkg::half_period_t half;
    chart_pkg::half_period_t cnt;
    logic is_rest;
    logic new_note;

    assign is_rest = cur.keys == '0;
    assign half = chart_pkg::note_half_period(cur);
    assign led = chart_pkg::note_led(cur);

    // Repeated notes keep the running wave
    assign new_note = pop && (head != cur);

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            cur <= '0;
        end else if (pop) begin
            cur <= head;
        end else if (!playing) begin
            cur <= '0;
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
            tone <= 1'b0;
        end else if (is_rest) begin
            cnt <= '0;
            tone <= 1'b0;
        end else if (new_note) begin
            cnt <= '0;
        end else if (cnt >= half - 1'b1) begin
            cnt <= '0;
            tone <= ~tone;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// ==== src/score_judge.sv ====
`timescale 1ns/1ns

module score_judge (
    input  logic              prog_clk,
    input  logic              rst,
    input  logic              step,
    input  logic              playing,
    input  chart_pkg::note_t  head,
    input  chart_pkg::note_t  keys_in,
    output play_pkg::score_t  score
);

    // hist1 is the input of the previous step
    chart_pkg::note_t hist1;
    chart_pkg::note_t hist2;
    chart_pkg::note_t hist3;
    play_pkg::score_t award;
    logic playing_q;
    logic play_begin;

    assign play_begin = playing && !playing_q;

    always_comb begin
        award = '0;
        // Rests score nothing
        if (head.keys != '0) begin
            if (head == keys_in || head == hist1) begin
                award = play_pkg::PTS_EXACT;
            end else if (head == hist2) begin
                award = play_pkg::PTS_LATE1;
            end else if (head == hist3) begin
                award = play_pkg::PTS_LATE2;
            end
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            playing_q <= 1'b0;
            hist1 <= '0;
            hist2 <= '0;
            hist3 <= '0;
            score <= '0;
        end else begin
            playing_q <= playing;
            if (play_begin) begin
                hist1 <= '0;
                hist2 <= '0;
                hist3 <= '0;
                score <= '0;
            end else if (step && playing) begin
                score <= score + award;
                hist3 <= hist2;
                hist2 <= hist1;
                hist1 <= keys_in;
            end
        end
    end

endmodule

// ==== src/play_fsm.sv ====
`timescale 1ns/1ns

module play_fsm (
    input  logic                    prog_clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic                    exit_req,
    input  play_pkg::index_t        note_total,
    input  logic                    step,
    input  play_pkg::index_t        step_count,
    input  logic                    empty,
    output logic                    pop,
    output logic                    run,
    output logic                    clear,
    output logic                    playing,
    output play_pkg::play_status_t  status
);

    play_pkg::play_state_e state;
    play_pkg::index_t index;
    logic idle_like;
    logic notes_left;
    logic countdown_end;

    assign idle_like = (state == play_pkg::IDLE) || (state == play_pkg::DONE);
    assign notes_left = index != note_total;
    assign countdown_end = step &&
        (step_count == play_pkg::index_t'(play_pkg::COUNTDOWN_STEPS - 1));

    assign run = (state == play_pkg::COUNTDOWN) || (state == play_pkg::PLAY);
    assign playing = state == play_pkg::PLAY;

    // Timer restarts with each new game
    assign clear = start && idle_like && !exit_req;

    // Empty queue at a step gives a rest
    assign pop = playing && step && notes_left && !empty;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            state <= play_pkg::IDLE;
            index <= '0;
        end else if (exit_req) begin
            state <= play_pkg::IDLE;
        end else begin
            case (state)
                play_pkg::IDLE, play_pkg::DONE: begin
                    if (start) begin
                        state <= play_pkg::COUNTDOWN;
                        index <= '0;
                    end
                end
                play_pkg::COUNTDOWN: begin
                    if (countdown_end) begin
                        state <= play_pkg::PLAY;
                    end
                end
                default: begin
                    if (step && !notes_left) begin
                        state <= play_pkg::DONE;
                    end else if (pop) begin
                        index <= index + 1'b1;
                    end
                end
            endcase
        end
    end

    always_comb begin
        status.state = state;
        status.index = index;
        status.done = state == play_pkg::DONE;
        status.digit = '0;
        // 3, 2, 1 over the countdown
        if (state == play_pkg::COUNTDOWN) begin
            status.digit = play_pkg::digit_t'(play_pkg::COUNTDOWN_DIGITS -
                step_count / play_pkg::DIGIT_STEPS);
        end
    end

endmodule

// ==== src/step_timer.sv ====
`timescale 1ns/1ns

module step_timer (
    input  logic              prog_clk,
    input  logic              rst,
    input  logic              run,
    input  logic              clear,
    output logic              step,
    output play_pkg::index_t  step_count
);

    play_pkg::cycle_t cyc;
    logic last_cycle;

    assign last_cycle = cyc == play_pkg::cycle_t'(play_pkg::STEP_CYCLES - 1);

    // Pulse lands in the last cycle of each step
    assign step = run && !clear && last_cycle;

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            cyc <= '0;
            step_count <= '0;
        end else if (clear) begin
            cyc <= '0;
            step_count <= '0;
        end else if (run) begin
            if (last_cycle) begin
                cyc <= '0;
                step_count <= step_count + 1'b1;
            end else begin
                cyc <= cyc + 1'b1;
            end
        end
    end

endmodule

// ==== src/note_queue.sv ====
`timescale 1ns/1ns

module note_queue (
    input  logic              prog_clk,
    input  logic              rst,
    input  chart_pkg::note_t  note_in,
    input  logic              note_valid,
    input  logic              pop,
    output chart_pkg::note_t  head,
    output logic              empty,
    output logic              credit_ret
);

    chart_pkg::note_t mem [play_pkg::QUEUE_DEPTH];
    play_pkg::qptr_t wr_ptr;
    play_pkg::qptr_t rd_ptr;
    logic do_pop;

    assign empty = wr_ptr == rd_ptr;
    assign do_pop = pop && !empty;

    // Empty queue reads as a rest
    assign head = empty ? '0 : mem[rd_ptr[play_pkg::QPTR_W-2:0]];

    always_ff @(posedge prog_clk) begin
        if (note_valid) begin
            mem[wr_ptr[play_pkg::QPTR_W-2:0]] <= note_in;
        end
    end

    always_ff @(posedge prog_clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            credit_ret <= 1'b0;
        end else begin
            // Source holds a credit for every push
            if (note_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            credit_ret <= do_pop;
        end
    end

endmodule

// ==== src/play_pkg.sv ====
package play_pkg;

    localparam int STEP_CYCLES = 8;
    localparam int DIGIT_STEPS = 4;
    localparam int COUNTDOWN_DIGITS = 3;
    localparam int COUNTDOWN_STEPS = COUNTDOWN_DIGITS * DIGIT_STEPS;
    localparam int QUEUE_DEPTH = 2;

    // Pointer carries one wrap bit above the address
    localparam int QPTR_W = $clog2(QUEUE_DEPTH) + 1;
    localparam int CYCLE_W = $clog2(STEP_CYCLES);

    typedef logic [13:0] score_t;
    typedef logic [7:0] index_t;
    typedef logic [1:0] digit_t;
    typedef logic [QPTR_W-1:0] qptr_t;
    typedef logic [CYCLE_W-1:0] cycle_t;

    // Points per lag
    localparam score_t PTS_EXACT = 14'd10;
    localparam score_t PTS_LATE1 = 14'd8;
    localparam score_t PTS_LATE2 = 14'd5;

    typedef enum logic [1:0] {
        IDLE,
        COUNTDOWN,
        PLAY,
        DONE
    } play_state_e;

    typedef struct packed {
        play_state_e state;
        digit_t digit;
        index_t index;
        logic done;
    } play_status_t;

endpackage

// ==== src/chart_pkg.sv ====
package chart_pkg;

    // One-hot keys, bit 0 is C
    typedef logic [6:0] key_t;

    // 00 middle, 01 up, 10 down
    typedef logic [1:0] oct_t;

    typedef struct packed {
        oct_t oct;
        key_t keys;
    } note_t;

    // Bit 0 octave shifted, bits 7..1 keys C..B
    typedef logic [7:0] led_t;

    typedef logic [11:0] half_period_t;

    // Middle C half period in cycles
    localparam half_period_t TONE_BASE = 12'd120;
    localparam half_period_t KEY_STEP = 12'd16;

    function automatic half_period_t note_half_period(input note_t note);
        half_period_t hp;
        hp = '0;
        // Lowest set key wins
        for (int i = 6; i >= 0; i--) begin
            if (note.keys[i]) begin
                hp = TONE_BASE - KEY_STEP * half_period_t'(i);
            end
        end
        if (note.oct == 2'b10) begin
            hp = hp << 1;
        end else if (note.oct == 2'b01) begin
            hp = hp >> 1;
        end
        return hp;
    endfunction

    function automatic led_t note_led(input note_t note);
        led_t pattern;
        pattern[0] = (note.oct != 2'b00) && (note.keys != '0);
        for (int i = 0; i < 7; i++) begin
            pattern[7 - i] = note.keys[i];
        end
        return pattern;
    endfunction

endpackage
